// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module dcache_tb -f vlog.f -o Vdcache_tb
	./obj_dir/Vdcache_tb > $(LOG) 2>&1; st=$$?; cat $(LOG); test $$st -eq 0
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: src/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// address split is tag | index | byte offset
`define DC_ADDR_W 32

`define DC_SETS 64
`define DC_INDEX_W 6

// four 32-bit words per line
`define DC_LINE_WORDS 4
`define DC_OFFSET_W 4

`define DC_TAG_W 22

`define DC_WAYS 2

`endif

// File: src/dcache_ctrl.sv
`include "dcache_config.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic                              clk,
    input  logic                              arst_n,
    // core side
    input  logic                              req_valid,
    input  cpu_req_t                          req,
    output logic                              req_ready,
    output logic                              rsp_valid,
    output cpu_rsp_t                          rsp,
    // memory side
    output logic                              mem_cmd_valid,
    input  logic                              mem_cmd_ready,
    output mem_cmd_t                          mem_cmd,
    output logic                              mem_wdata_valid,
    input  logic                              mem_wdata_ready,
    output mem_beat_t                         mem_wdata,
    input  logic                              mem_rdata_valid,
    input  mem_beat_t                         mem_rdata,
    input  logic                              mem_wdone,
    // array results
    input  lookup_t                           lookup,
    input  logic [`DC_WAYS-1:0][`DC_LINE_WORDS-1:0][31:0] rd_line,
    // tag lookup control
    output logic [`DC_INDEX_W-1:0]            arr_index,
    output logic [`DC_TAG_W-1:0]              lookup_tag,
    output logic                              upd_en,
    output logic                              upd_way,
    output logic [`DC_TAG_W-1:0]              upd_tag,
    output logic                              set_dirty,
    output logic                              touch_en,
    output logic                              touch_way,
    // data array writes
    output logic                              wr_en,
    output logic                              wr_way,
    output logic [`DC_INDEX_W-1:0]            wr_index,
    output logic [$clog2(`DC_LINE_WORDS)-1:0] wr_word,
    output logic [3:0]                        wr_strb,
    output logic [31:0]                       wr_data
);

    localparam int WORD_W = $clog2(`DC_LINE_WORDS);

    dc_state_t state_q;
    dc_state_t state_d;

    cpu_req_t             req_q;
    cpu_rsp_t             rsp_q;
    logic                 victim_way_q;
    logic [`DC_TAG_W-1:0] victim_tag_q;
    logic [WORD_W-1:0]    beat_cnt;

    logic                   accept;
    logic                   beat_last;
    logic [`DC_TAG_W-1:0]   req_tag;
    logic [`DC_INDEX_W-1:0] req_index;
    logic [WORD_W-1:0]      req_word;
    logic [31:0]            hit_word;
    logic [31:0]            merged_word;
    logic                   hit_idx;
    logic                   store_hit;
    logic                   refill_beat;

    assign req_tag   = req_q.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign req_index = req_q.addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign req_word  = req_q.addr[2 +: WORD_W];

    assign req_ready = (state_q == st_idle);
    assign accept    = req_valid && req_ready;
    assign beat_last = (beat_cnt == WORD_W'(`DC_LINE_WORDS - 1));

    // both arrays latch the incoming index on the accept edge
    assign arr_index  = (state_q == st_idle) ? req.addr[`DC_OFFSET_W +: `DC_INDEX_W] : req_index;
    assign lookup_tag = req_tag;

    // hit way select, then store bytes merged over it
    always_comb begin
        hit_word = '0;
        hit_idx  = 1'b0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (lookup.hit_way[w]) begin
                hit_word = rd_line[w][req_word];
                hit_idx  = 1'(w);
            end
        end
        merged_word = hit_word;
        if (req_q.write) begin
            for (int b = 0; b < 4; b++) begin
                if (req_q.strb[b]) begin
                    merged_word[8*b +: 8] = req_q.wdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            st_idle:     if (accept) state_d = st_lookup;
            st_lookup: begin
                if (lookup.hit) begin
                    state_d = st_respond;
                end else if (lookup.victim_valid && lookup.victim_dirty) begin
                    state_d = st_wb_cmd;
                end else begin
                    state_d = st_rf_cmd;
                end
            end
            st_respond:  state_d = st_idle;
            st_wb_cmd:   if (mem_cmd_ready) state_d = st_wb_data;
            st_wb_data:  if (mem_wdata_ready && beat_last) state_d = st_wb_wait;
            st_wb_wait:  if (mem_wdone) state_d = st_rf_cmd;
            st_rf_cmd:   if (mem_cmd_ready) state_d = st_rf_data;
            st_rf_data:  if (mem_rdata_valid && mem_rdata.last) state_d = st_rf_write;
            // replay the original request as a hit
            st_rf_write: state_d = st_lookup;
            default:     state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= st_idle;
            beat_cnt <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == st_wb_cmd || state_q == st_rf_cmd) begin
                beat_cnt <= '0;
            end else if ((state_q == st_wb_data && mem_wdata_ready) || refill_beat) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
        if (state_q == st_lookup) begin
            if (lookup.hit) begin
                rsp_q.rdata <= merged_word;
            end else begin
                victim_way_q <= lookup.victim_way;
                victim_tag_q <= lookup.victim_tag;
            end
        end
    end

    assign rsp_valid = (state_q == st_respond);
    assign rsp       = rsp_q;

    // one command at a time, writeback before refill
    assign mem_cmd_valid = (state_q == st_wb_cmd) || (state_q == st_rf_cmd);
    always_comb begin
        mem_cmd.write = (state_q == st_wb_cmd);
        if (state_q == st_wb_cmd) begin
            mem_cmd.addr = {victim_tag_q, req_index, {`DC_OFFSET_W{1'b0}}};
        end else begin
            mem_cmd.addr = {req_tag, req_index, {`DC_OFFSET_W{1'b0}}};
        end
    end

    assign mem_wdata_valid = (state_q == st_wb_data);
    assign mem_wdata.data  = rd_line[victim_way_q][beat_cnt];
    assign mem_wdata.last  = beat_last;

    assign store_hit   = (state_q == st_lookup) && lookup.hit && req_q.write;
    assign refill_beat = (state_q == st_rf_data) && mem_rdata_valid;

    assign touch_en  = (state_q == st_lookup) && lookup.hit;
    assign touch_way = hit_idx;
    assign set_dirty = store_hit;

    assign upd_en  = (state_q == st_rf_write);
    assign upd_way = victim_way_q;
    assign upd_tag = req_tag;

    // store hits and refill beats share the write port
    assign wr_en    = store_hit || refill_beat;
    assign wr_way   = store_hit ? hit_idx : victim_way_q;
    assign wr_index = req_index;
    assign wr_word  = store_hit ? req_word : beat_cnt;
    assign wr_strb  = store_hit ? req_q.strb : 4'hf;
    assign wr_data  = store_hit ? req_q.wdata : mem_rdata.data;

endmodule

// File: src/dcache_data_array.sv
`include "dcache_config.svh"

module dcache_data_array (
    input  logic                              clk,
    input  logic [`DC_INDEX_W-1:0]            rd_index,
    input  logic                              wr_en,
    input  logic                              wr_way,
    input  logic [`DC_INDEX_W-1:0]            wr_index,
    input  logic [$clog2(`DC_LINE_WORDS)-1:0] wr_word,
    input  logic [3:0]                        wr_strb,
    input  logic [31:0]                       wr_data,
    output logic [`DC_WAYS-1:0][`DC_LINE_WORDS-1:0][31:0] rd_line
);

    logic [`DC_INDEX_W-1:0] rd_index_q;

    always_ff @(posedge clk) begin
        rd_index_q <= rd_index;
    end

    // one bank per way, all read at the same index
    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        logic [`DC_LINE_WORDS-1:0][31:0] line_mem [`DC_SETS];
        logic                            way_we;

        assign way_we = wr_en && (wr_way == 1'(w));

        // byte lanes masked by strobe
        always_ff @(posedge clk) begin
            if (way_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr_strb[b]) begin
                        line_mem[wr_index][wr_word][8*b +: 8] <= wr_data[8*b +: 8];
                    end
                end
            end
        end

        assign rd_line[w] = line_mem[rd_index_q];
    end

endmodule

// File: src/dcache_pkg.sv
`include "dcache_config.svh"

package dcache_pkg;

    typedef struct packed {
        logic                  write;
        logic [`DC_ADDR_W-1:0] addr;
        logic [31:0]           wdata;
        logic [3:0]            strb;
    } cpu_req_t;

    // store responses carry the merged word
    typedef struct packed {
        logic [31:0] rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic                  write;
        logic [`DC_ADDR_W-1:0] addr;
    } mem_cmd_t;

    // shared by write beats and read returns
    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } mem_beat_t;

    typedef struct packed {
        logic [`DC_WAYS-1:0]  hit_way;
        logic                 hit;
        logic                 victim_way;
        logic                 victim_valid;
        logic                 victim_dirty;
        logic [`DC_TAG_W-1:0] victim_tag;
    } lookup_t;

    typedef enum logic [3:0] {
        st_idle,
        st_lookup,
        st_respond,
        st_wb_cmd,
        st_wb_data,
        st_wb_wait,
        st_rf_cmd,
        st_rf_data,
        st_rf_write
    } dc_state_t;

endpackage

// File: src/dcache_tag_lookup.sv
`include "dcache_config.svh"

module dcache_tag_lookup import dcache_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`DC_INDEX_W-1:0] index,
    input  logic [`DC_TAG_W-1:0]   lookup_tag,
    input  logic                   upd_en,
    input  logic                   upd_way,
    input  logic [`DC_TAG_W-1:0]   upd_tag,
    input  logic                   set_dirty,
    input  logic                   touch_en,
    input  logic                   touch_way,
    output lookup_t                lookup
);

    logic [`DC_TAG_W-1:0] tag_mem [`DC_WAYS][`DC_SETS];

    logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid_q;
    logic [`DC_WAYS-1:0][`DC_SETS-1:0] dirty_q;

    // lru bit names the way to evict next
    logic [`DC_SETS-1:0] lru_q;

    logic [`DC_INDEX_W-1:0] index_q;
    logic                   victim;

    // index captured alongside the data array
    always_ff @(posedge clk) begin
        index_q <= index;
        if (upd_en) begin
            tag_mem[upd_way][index_q] <= upd_tag;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            // refill completion leaves the line clean
            if (upd_en) begin
                valid_q[upd_way][index_q] <= 1'b1;
                dirty_q[upd_way][index_q] <= 1'b0;
            end
            // store hit marks the touched way dirty
            if (set_dirty) begin
                dirty_q[touch_way][index_q] <= 1'b1;
            end
            if (touch_en) begin
                lru_q[index_q] <= ~touch_way;
            end
        end
    end

    // first invalid way wins, else lru choice
    always_comb begin
        victim = lru_q[index_q];
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[w][index_q]) begin
                victim = 1'(w);
            end
        end
    end

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            lookup.hit_way[w] = valid_q[w][index_q] &&
                                (tag_mem[w][index_q] == lookup_tag);
        end
        lookup.hit          = |lookup.hit_way;
        lookup.victim_way   = victim;
        lookup.victim_valid = valid_q[victim][index_q];
        lookup.victim_dirty = dirty_q[victim][index_q];
        lookup.victim_tag   = tag_mem[victim][index_q];
    end

endmodule

// File: src/dcache_top.sv
`include "dcache_config.svh"

module dcache_top import dcache_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      req_valid,
    output logic      req_ready,
    input  cpu_req_t  req,
    output logic      rsp_valid,
    output cpu_rsp_t  rsp,
    output logic      mem_cmd_valid,
    input  logic      mem_cmd_ready,
    output mem_cmd_t  mem_cmd,
    output logic      mem_wdata_valid,
    input  logic      mem_wdata_ready,
    output mem_beat_t mem_wdata,
    input  logic      mem_rdata_valid,
    input  mem_beat_t mem_rdata,
    input  logic      mem_wdone
);

    lookup_t                                       lookup;
    logic [`DC_WAYS-1:0][`DC_LINE_WORDS-1:0][31:0] rd_line;

    logic [`DC_INDEX_W-1:0] arr_index;
    logic [`DC_TAG_W-1:0]   lookup_tag;
    logic                   upd_en;
    logic                   upd_way;
    logic [`DC_TAG_W-1:0]   upd_tag;
    logic                   set_dirty;
    logic                   touch_en;
    logic                   touch_way;

    logic                              wr_en;
    logic                              wr_way;
    logic [`DC_INDEX_W-1:0]            wr_index;
    logic [$clog2(`DC_LINE_WORDS)-1:0] wr_word;
    logic [3:0]                        wr_strb;
    logic [31:0]                       wr_data;

    // tags and data looked up side by side on the same index
    dcache_tag_lookup u_tag_lookup (
        .clk        (clk),
        .arst_n     (arst_n),
        .index      (arr_index),
        .lookup_tag (lookup_tag),
        .upd_en     (upd_en),
        .upd_way    (upd_way),
        .upd_tag    (upd_tag),
        .set_dirty  (set_dirty),
        .touch_en   (touch_en),
        .touch_way  (touch_way),
        .lookup     (lookup)
    );

    dcache_data_array u_data_array (
        .clk      (clk),
        .rd_index (arr_index),
        .wr_en    (wr_en),
        .wr_way   (wr_way),
        .wr_index (wr_index),
        .wr_word  (wr_word),
        .wr_strb  (wr_strb),
        .wr_data  (wr_data),
        .rd_line  (rd_line)
    );

    dcache_ctrl u_ctrl (
        .clk             (clk),
        .arst_n          (arst_n),
        .req_valid       (req_valid),
        .req             (req),
        .req_ready       (req_ready),
        .rsp_valid       (rsp_valid),
        .rsp             (rsp),
        .mem_cmd_valid   (mem_cmd_valid),
        .mem_cmd_ready   (mem_cmd_ready),
        .mem_cmd         (mem_cmd),
        .mem_wdata_valid (mem_wdata_valid),
        .mem_wdata_ready (mem_wdata_ready),
        .mem_wdata       (mem_wdata),
        .mem_rdata_valid (mem_rdata_valid),
        .mem_rdata       (mem_rdata),
        .mem_wdone       (mem_wdone),
        .lookup          (lookup),
        .rd_line         (rd_line),
        .arr_index       (arr_index),
        .lookup_tag      (lookup_tag),
        .upd_en          (upd_en),
        .upd_way         (upd_way),
        .upd_tag         (upd_tag),
        .set_dirty       (set_dirty),
        .touch_en        (touch_en),
        .touch_way       (touch_way),
        .wr_en           (wr_en),
        .wr_way          (wr_way),
        .wr_index        (wr_index),
        .wr_word         (wr_word),
        .wr_strb         (wr_strb),
        .wr_data         (wr_data)
    );

endmodule

// File: verification/dcache_checker.sv
module dcache_checker import dcache_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      req_valid,
    input  logic      req_ready,
    input  cpu_req_t  req,
    input  logic      rsp_valid,
    input  cpu_rsp_t  rsp,
    input  logic      mem_cmd_valid,
    input  logic      mem_cmd_ready,
    input  mem_cmd_t  mem_cmd,
    input  logic      mem_wdata_valid,
    input  logic      mem_wdata_ready,
    input  mem_beat_t mem_wdata,
    input  logic      mem_wdone,
    input  logic [31:0] row_exp,
    input  logic      row_exp_rd,
    input  logic      row_exp_wb,
    output int        err_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    // words as the core has written them
    logic [31:0] shadow [logic [31:0]];

    // lines with stores not yet written back
    logic        dirty_line [logic [31:0]];

    cpu_req_t    cur = '0;
    int          errs = 0;
    int          cyc = 0;
    int          acc_cyc = 0;
    int          beat = 0;
    logic        seen_rd = 1'b0;
    logic        seen_wb = 1'b0;
    logic        wb_open = 1'b0;
    logic        reset_checked = 1'b0;
    logic [31:0] wb_addr = '0;

    assign err_cnt = errs;

    function automatic logic [31:0] expected_word(input logic [31:0] a);
        logic [31:0] wa;
        wa = {a[31:2], 2'b00};
        if (shadow.exists(wa)) begin
            return shadow[wa];
        end
        return wa ^ 32'h5a5a_0000;
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
        errs++;
    endtask

    task automatic report_fault(input string msg);
        $display("error at %0t: %s", $time, msg);
        errs++;
    endtask

    always @(posedge clk) begin
        if (arst_n) begin
            if (!reset_checked) begin
                if (!req_ready || rsp_valid || mem_cmd_valid || mem_wdata_valid) begin
                    report_fault("outputs not in their reset state after reset");
                end
                reset_checked = 1'b1;
            end
            if (req_valid && req_ready) begin
                cur     = req;
                acc_cyc = cyc;
                seen_rd = 1'b0;
                seen_wb = 1'b0;
                if (req.write) begin
                    logic [31:0] w;
                    w = expected_word(req.addr);
                    for (int b = 0; b < 4; b++) begin
                        if (req.strb[b]) begin
                            w[8*b +: 8] = req.wdata[8*b +: 8];
                        end
                    end
                    shadow[{req.addr[31:2], 2'b00}] = w;
                    dirty_line[{req.addr[31:4], 4'h0}] = 1'b1;
                end
            end
            if (mem_cmd_valid && mem_cmd_ready) begin
                if (mem_cmd.write) begin
                    if (seen_rd) begin
                        report_fault("writeback command sent after the refill command");
                    end
                    if (mem_cmd.addr[9:4] != cur.addr[9:4] || mem_cmd.addr[3:0] != 4'h0) begin
                        report_fault("writeback address is not a line in the request's set");
                    end
                    if (!dirty_line.exists(mem_cmd.addr)) begin
                        report_fault("writeback of a line that holds no unwritten store");
                    end else begin
                        dirty_line.delete(mem_cmd.addr);
                    end
                    seen_wb = 1'b1;
                    wb_open = 1'b1;
                    wb_addr = mem_cmd.addr;
                    beat    = 0;
                end else begin
                    if (wb_open) begin
                        report_fault("refill command sent before the writeback completed");
                    end
                    if (seen_rd) begin
                        report_fault("more than one refill command for one request");
                    end
                    seen_rd = 1'b1;
                    if (mem_cmd.addr != {cur.addr[31:4], 4'h0}) begin
                        report_value("mem_cmd.addr", {cur.addr[31:4], 4'h0}, mem_cmd.addr);
                    end
                end
            end
            if (mem_wdata_valid && mem_wdata_ready) begin
                if (!wb_open || beat > 3) begin
                    report_fault("write beat sent outside a writeback");
                end else begin
                    if (mem_wdata.data != expected_word(wb_addr + 32'(beat * 4))) begin
                        report_value("mem_wdata.data", expected_word(wb_addr + 32'(beat * 4)),
                                     mem_wdata.data);
                    end
                    if (mem_wdata.last != (beat == 3)) begin
                        report_value("mem_wdata.last", {31'b0, beat == 3},
                                     {31'b0, mem_wdata.last});
                    end
                    beat++;
                end
            end
            if (mem_wdone) begin
                if (mem_wdata_valid) begin
                    report_fault("write beat still offered after the last beat");
                end
                wb_open = 1'b0;
            end
            if (rsp_valid) begin
                if (rsp.rdata != row_exp) begin
                    report_value("rsp.rdata", row_exp, rsp.rdata);
                end
                if (seen_rd != row_exp_rd) begin
                    report_fault("refill command presence differs from the expected access");
                end
                if (seen_wb != row_exp_wb) begin
                    report_fault("writeback presence differs from the expected access");
                end
                if (!row_exp_rd && (cyc - acc_cyc) != 2) begin
                    report_fault("hit response did not arrive 2 cycles after acceptance");
                end
            end
            cyc++;
        end
    end

endmodule

// File: verification/dcache_properties.sv
module dcache_properties import dcache_pkg::*; (
    input logic      clk,
    input logic      arst_n,
    input logic      req_valid,
    input logic      req_ready,
    input logic      rsp_valid,
    input logic      mem_cmd_valid,
    input logic      mem_cmd_ready,
    input mem_cmd_t  mem_cmd,
    input logic      mem_wdata_valid,
    input logic      mem_wdata_ready,
    input mem_beat_t mem_wdata
);
    timeunit 1ns;
    timeprecision 1ps;

    // request in flight
    logic busy;

    // count of failed assertions
    int fail_cnt = 0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
        end else if (req_valid && req_ready) begin
            busy <= 1'b1;
        end else if (rsp_valid) begin
            busy <= 1'b0;
        end
    end

    cmd_hold: assert property (@(posedge clk) disable iff (!arst_n)
        mem_cmd_valid && !mem_cmd_ready |=> mem_cmd_valid && $stable(mem_cmd))
        else begin
            $error("memory command changed while stalled");
            fail_cnt++;
        end

    wdata_hold: assert property (@(posedge clk) disable iff (!arst_n)
        mem_wdata_valid && !mem_wdata_ready |=> mem_wdata_valid && $stable(mem_wdata))
        else begin
            $error("write beat changed while stalled");
            fail_cnt++;
        end

    rsp_single: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |=> !rsp_valid)
        else begin
            $error("rsp_valid high on two cycles in a row");
            fail_cnt++;
        end

    ready_low: assert property (@(posedge clk) disable iff (!arst_n)
        busy |-> !req_ready)
        else begin
            $error("req_ready high while a request is in flight");
            fail_cnt++;
        end

endmodule

bind dcache_top dcache_properties u_props (
    .clk             (clk),
    .arst_n          (arst_n),
    .req_valid       (req_valid),
    .req_ready       (req_ready),
    .rsp_valid       (rsp_valid),
    .mem_cmd_valid   (mem_cmd_valid),
    .mem_cmd_ready   (mem_cmd_ready),
    .mem_cmd         (mem_cmd),
    .mem_wdata_valid (mem_wdata_valid),
    .mem_wdata_ready (mem_wdata_ready),
    .mem_wdata       (mem_wdata)
);

// File: verification/dcache_tb.sv
module dcache_tb import dcache_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [31:0] exp;
        logic        exp_rd;
        logic        exp_wb;
    } row_t;

    logic      clk = 1'b0;
    logic      arst_n = 1'b0;
    logic      req_valid = 1'b0;
    logic      req_ready;
    cpu_req_t  req = '0;
    logic      rsp_valid;
    cpu_rsp_t  rsp;
    logic      mem_cmd_valid;
    logic      mem_cmd_ready = 1'b0;
    mem_cmd_t  mem_cmd;
    logic      mem_wdata_valid;
    logic      mem_wdata_ready = 1'b0;
    mem_beat_t mem_wdata;
    logic      mem_rdata_valid = 1'b0;
    mem_beat_t mem_rdata = '0;
    logic      mem_wdone = 1'b0;

    logic [31:0] row_exp = '0;
    logic        row_exp_rd = 1'b0;
    logic        row_exp_wb = 1'b0;
    int          err_cnt;
    int          seed = 32'hb6dc_611d;
    row_t        stim [$];

    // backing memory, pattern until written back
    logic [31:0] mem [logic [31:0]];

    always #5 clk = ~clk;

    dcache_top u_dut (.*);

    dcache_checker u_check (.*);

    function automatic logic [31:0] mem_read(input logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'h5a5a_0000;
    endfunction

    task automatic add_row(input logic w, input logic [31:0] a, input logic [31:0] d,
                           input logic [3:0] s, input logic [31:0] e,
                           input logic rd, input logic wb);
        row_t r;
        r = '{w, a, d, s, e, rd, wb};
        stim.push_back(r);
    endtask

    task automatic serve_write(input logic [31:0] base);
        int n;
        n = 0;
        while (n < 4) begin
            @(posedge clk);
            if (mem_wdata_valid && mem_wdata_ready) begin
                mem[base + 32'(n * 4)] = mem_wdata.data;
                n++;
            end
        end
        #1 mem_wdone = 1'b1;
        @(posedge clk);
        #1 mem_wdone = 1'b0;
    endtask

    task automatic serve_read(input logic [31:0] base);
        int delay;
        for (int i = 0; i < 4; i++) begin
            delay = $unsigned($random(seed)) % 4;
            repeat (delay) @(posedge clk);
            #1;
            mem_rdata_valid = 1'b1;
            mem_rdata.data  = mem_read(base + 32'(i * 4));
            mem_rdata.last  = (i == 3);
            @(posedge clk);
            #1 mem_rdata_valid = 1'b0;
        end
    endtask

    task automatic apply_row(input row_t r);
        @(posedge clk);
        #1;
        row_exp    = r.exp;
        row_exp_rd = r.exp_rd;
        row_exp_wb = r.exp_wb;
        req        = '{r.write, r.addr, r.wdata, r.strb};
        req_valid  = 1'b1;
        do @(posedge clk); while (!req_ready);
        #1 req_valid = 1'b0;
        do @(posedge clk); while (!rsp_valid);
    endtask

    // random ready gaps
    always @(posedge clk) begin
        #1;
        mem_cmd_ready   = ($random(seed) % 4) != 0;
        mem_wdata_ready = ($random(seed) % 4) != 0;
    end

    initial begin : memory_model
        mem_cmd_t cmd;
        forever begin
            @(posedge clk);
            if (mem_cmd_valid && mem_cmd_ready) begin
                cmd = mem_cmd;
                if (cmd.write) begin
                    serve_write(cmd.addr);
                end else begin
                    serve_read(cmd.addr);
                end
            end
        end
    end

    initial begin : watchdog
        #1;
        repeat (stim.size() * 60 + 100) @(posedge clk);
        $display("timeout: the test table did not complete in time");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        // set 5 holds tags 4, 8 and 12; set 16 holds tags 0 to 3
        add_row(1'b0, 32'h0000_1054, 32'h0, 4'h0, 32'h5a5a_1054, 1'b1, 1'b0);
        add_row(1'b0, 32'h0000_1058, 32'h0, 4'h0, 32'h5a5a_1058, 1'b0, 1'b0);
        add_row(1'b1, 32'h0000_1054, 32'ha1b2_c3d4, 4'b0101, 32'h5ab2_10d4, 1'b0, 1'b0);
        add_row(1'b0, 32'h0000_1054, 32'h0, 4'h0, 32'h5ab2_10d4, 1'b0, 1'b0);
        add_row(1'b0, 32'h0000_2050, 32'h0, 4'h0, 32'h5a5a_2050, 1'b1, 1'b0);
        add_row(1'b0, 32'h0000_205c, 32'h0, 4'h0, 32'h5a5a_205c, 1'b0, 1'b0);
        add_row(1'b0, 32'h0000_3050, 32'h0, 4'h0, 32'h5a5a_3050, 1'b1, 1'b1);
        add_row(1'b0, 32'h0000_1054, 32'h0, 4'h0, 32'h5ab2_10d4, 1'b1, 1'b0);
        add_row(1'b1, 32'h0000_0100, 32'h1122_3344, 4'hf, 32'h1122_3344, 1'b1, 1'b0);
        add_row(1'b1, 32'h0000_0500, 32'hff00_0000, 4'h8, 32'hff5a_0500, 1'b1, 1'b0);
        add_row(1'b0, 32'h0000_0900, 32'h0, 4'h0, 32'h5a5a_0900, 1'b1, 1'b1);
        add_row(1'b0, 32'h0000_0d04, 32'h0, 4'h0, 32'h5a5a_0d04, 1'b1, 1'b1);
        add_row(1'b0, 32'h0000_0100, 32'h0, 4'h0, 32'h1122_3344, 1'b1, 1'b0);
        add_row(1'b0, 32'h0000_0500, 32'h0, 4'h0, 32'hff5a_0500, 1'b1, 1'b0);
        add_row(1'b0, 32'h0000_1054, 32'h0, 4'h0, 32'h5ab2_10d4, 1'b0, 1'b0);

        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;
        foreach (stim[i]) begin
            apply_row(stim[i]);
        end
        @(posedge clk);
        $display("rows applied %0d, errors %0d, assertion failures %0d", stim.size(), err_cnt,
                 u_dut.u_props.fail_cnt);
        if (err_cnt == 0 && u_dut.u_props.fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+src
src/dcache_pkg.sv
src/dcache_tag_lookup.sv
src/dcache_data_array.sv
src/dcache_ctrl.sv
src/dcache_top.sv
verification/dcache_checker.sv
verification/dcache_properties.sv
verification/dcache_tb.sv
